/* dv/rv_core_sva.sv */
`default_nettype none

module rv_core_sva (
    input logic clk,
    input logic i_reset,
    input logic i_load_we,
    input logic i_data_req,
    input logic i_fetch_grant,
    input logic i_retire_valid,
    input logic i_halted
);
    timeunit 1ns;
    timeprecision 100ps;

    logic data_grant;

    // Loader wins over data
    assign data_grant = i_data_req && !i_load_we;

    one_grant: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0({i_load_we, data_grant, i_fetch_grant}))
        else $error("More than one memory user granted in a cycle");

    data_before_fetch: assert property (@(posedge clk) disable iff (i_reset)
        i_data_req |-> !i_fetch_grant)
        else $error("Fetch granted while the data port requests");

    halt_sticky: assert property (@(posedge clk) disable iff (i_reset)
        i_halted |=> i_halted)
        else $error("o_halted fell");

    quiet_after_halt: assert property (@(posedge clk) disable iff (i_reset)
        i_halted |-> !i_retire_valid)
        else $error("Retire seen while halted");

endmodule

bind rv_core_top rv_core_sva u_sva (
    .clk(clk),
    .i_reset(i_reset),
    .i_load_we(i_load_we),
    .i_data_req(ex_mem_q.mem_write || ex_mem_q.mem_to_reg),
    .i_fetch_grant(fetch_grant),
    .i_retire_valid(o_retire_valid),
    .i_halted(o_halted)
);

`default_nettype wire

/* dv/rv_core_tb.sv */
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_core_pkg::*;

    localparam int PROG_LEN       = 48;
    localparam int DATA_BASE      = 256;
    localparam int DATA_WORDS     = 16;
    localparam int RESET_CYCLES   = 8;
    localparam int RETIRE_TIMEOUT = 64;
    localparam int HALT_TIMEOUT   = 32;
    localparam int HOLD_CYCLES    = 8;

    typedef enum int {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_SW} kind_e;

    logic     clk;
    logic     i_reset;
    logic     i_load_we;
    addr_t    i_load_addr;
    word_t    i_load_data;
    logic     o_retire_valid;
    reg_idx_t o_retire_rd;
    word_t    o_retire_data;
    logic     o_halted;

    integer   seed;
    int       errors;
    int       load_cycles;

    insn_t    prog [PROG_LEN+1];
    kind_e    insn_kind [PROG_LEN];
    reg_idx_t insn_rd [PROG_LEN];
    reg_idx_t insn_rs1 [PROG_LEN];
    reg_idx_t insn_rs2 [PROG_LEN];
    word_t    insn_imm [PROG_LEN];
    word_t    data_init [DATA_WORDS];

    // Expected (rd, value) of every register write in program order
    reg_idx_t exp_rd [$];
    word_t    exp_val [$];

    rv_core_top UUT (
        .clk(clk),
        .i_reset(i_reset),
        .i_load_we(i_load_we),
        .i_load_addr(i_load_addr),
        .i_load_data(i_load_data),
        .o_retire_valid(o_retire_valid),
        .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data),
        .o_halted(o_halted)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    task automatic flag_mismatch(input string name, input word_t expected, input word_t actual);
        errors++;
        $display("[ERROR] %0.1f ns: %s expected %h, got %h", $realtime, name, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t random_imm();
        logic [11:0] imm12;
        imm12 = 12'($random(seed));
        return {{20{imm12[11]}}, imm12};
    endfunction

    // RV32I encodings for the supported instructions
    function automatic insn_t encode_insn(input kind_e kind, input reg_idx_t rd,
                                          input reg_idx_t rs1, input reg_idx_t rs2,
                                          input word_t imm);
        insn_t insn;
        case (kind)
            K_ADD:   insn = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   insn = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_XOR:   insn = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_OR:    insn = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_AND:   insn = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_ADDI:  insn = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LW:    insn = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            default: insn = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        endcase
        return insn;
    endfunction

    function automatic void place_insn(input int idx, input kind_e kind, input reg_idx_t rd,
                                       input reg_idx_t rs1, input reg_idx_t rs2,
                                       input word_t imm);
        insn_kind[idx] = kind;
        insn_rd[idx]   = rd;
        insn_rs1[idx]  = rs1;
        insn_rs2[idx]  = rs2;
        insn_imm[idx]  = imm;
        prog[idx]      = encode_insn(kind, rd, rs1, rs2, imm);
    endfunction

    function automatic word_t data_slot_addr();
        return word_t'((DATA_BASE + pick(DATA_WORDS)) * 4);
    endfunction

    task automatic build_program();
        int    k;
        word_t slot;
        word_t imm;
        // Back-to-back dependences, then a store and a later load of the same word
        slot = data_slot_addr();
        place_insn(0, K_ADDI, 5'd1, 5'd0, 5'd0, random_imm());
        place_insn(1, K_ADDI, 5'd2, 5'd1, 5'd0, random_imm());
        place_insn(2, K_ADD, 5'd3, 5'd1, 5'd2, '0);
        place_insn(3, K_SW, 5'd0, 5'd0, 5'd3, slot);
        place_insn(4, K_SUB, 5'd4, 5'd3, 5'd2, '0);
        place_insn(5, K_LW, 5'd5, 5'd0, 5'd0, slot);
        place_insn(6, K_XOR, 5'd6, 5'd5, 5'd4, '0);
        for (int i = 7; i < PROG_LEN; i++)
        begin
            k = pick(8);
            if (k == int'(K_LW) || k == int'(K_SW))
            begin
                imm = data_slot_addr();
                place_insn(i, kind_e'(k), reg_idx_t'(1 + pick(7)), 5'd0,
                           reg_idx_t'(1 + pick(7)), imm);
            end
            else
            begin
                imm = (k == int'(K_ADDI)) ? random_imm() : '0;
                place_insn(i, kind_e'(k), reg_idx_t'(1 + pick(7)), reg_idx_t'(1 + pick(7)),
                           reg_idx_t'(1 + pick(7)), imm);
            end
        end
        prog[PROG_LEN] = `HALT_INSN;
        for (int i = 0; i < DATA_WORDS; i++)
        begin
            data_init[i] = $random(seed);
        end
    endtask

    // Instruction-set model stepping one instruction at a time
    task automatic run_model();
        word_t regs [32];
        word_t mem [DATA_WORDS];
        word_t a;
        word_t b;
        word_t v;
        int    idx;
        for (int i = 0; i < 32; i++)
        begin
            regs[i] = '0;
        end
        for (int i = 0; i < DATA_WORDS; i++)
        begin
            mem[i] = data_init[i];
        end
        for (int i = 0; i < PROG_LEN; i++)
        begin
            a   = regs[insn_rs1[i]];
            b   = regs[insn_rs2[i]];
            idx = int'((a + insn_imm[i]) >> 2) - DATA_BASE;
            v   = '0;
            case (insn_kind[i])
                K_ADD:  v = a + b;
                K_SUB:  v = a - b;
                K_AND:  v = a & b;
                K_OR:   v = a | b;
                K_XOR:  v = a ^ b;
                K_ADDI: v = a + insn_imm[i];
                K_LW:   v = mem[idx];
                K_SW:   mem[idx] = b;
            endcase
            if (insn_kind[i] != K_SW)
            begin
                regs[insn_rd[i]] = v;
                exp_rd.push_back(insn_rd[i]);
                exp_val.push_back(v);
            end
        end
    endtask

    task automatic expect_idle();
        assert (!o_retire_valid)
            else flag_mismatch("o_retire_valid", '0, word_t'(o_retire_valid));
        assert (!o_halted)
            else flag_mismatch("o_halted", '0, word_t'(o_halted));
    endtask

    task automatic write_word(input addr_t addr, input word_t data);
        @(posedge clk);
        i_load_we   <= 1'b1;
        i_load_addr <= addr;
        i_load_data <= data;
        load_cycles++;
        // Loader outranks fetch, so loading may run on after reset
        if (load_cycles == RESET_CYCLES)
        begin
            i_reset <= 1'b0;
        end
        @(negedge clk);
        if (load_cycles >= RESET_CYCLES)
        begin
            expect_idle();
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i <= PROG_LEN; i++)
        begin
            write_word(addr_t'(i * 4), prog[i]);
        end
        for (int i = 0; i < DATA_WORDS; i++)
        begin
            write_word(addr_t'((DATA_BASE + i) * 4), data_init[i]);
        end
        @(posedge clk);
        i_load_we <= 1'b0;
    endtask

    task automatic check_retires();
        int idle;
        int count;
        idle  = 0;
        count = 0;
        while (exp_rd.size() != 0)
        begin
            @(negedge clk);
            assert (!o_halted)
                else abort_run("o_halted rose before every instruction had retired");
            if (o_retire_valid)
            begin
                assert (o_retire_rd == exp_rd[0])
                    else flag_mismatch("o_retire_rd", word_t'(exp_rd[0]), word_t'(o_retire_rd));
                assert (o_retire_data == exp_val[0])
                    else flag_mismatch("o_retire_data", exp_val[0], o_retire_data);
                void'(exp_rd.pop_front());
                void'(exp_val.pop_front());
                idle = 0;
                count++;
            end
            else
            begin
                idle++;
                assert (idle < RETIRE_TIMEOUT)
                    else abort_run($sformatf("Timed out waiting for retire number %0d", count));
            end
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!o_halted)
        begin
            @(negedge clk);
            cycles++;
            assert (!o_retire_valid)
                else abort_run("An instruction retired after the last expected one");
            assert (o_halted || cycles < HALT_TIMEOUT)
                else abort_run("Timed out waiting for o_halted");
        end
        for (int i = 0; i < HOLD_CYCLES; i++)
        begin
            @(negedge clk);
            assert (o_halted)
                else abort_run("o_halted fell after the core had halted");
            assert (!o_retire_valid)
                else abort_run("An instruction retired while o_halted was high");
        end
    endtask

    initial
    begin
        seed        = 71785;
        errors      = 0;
        load_cycles = 0;
        i_reset     <= 1'b1;
        i_load_we   <= 1'b0;
        i_load_addr <= '0;
        i_load_data <= '0;
        build_program();
        run_model();
        load_memory();
        check_retires();
        wait_for_halt();
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/rv_core_pkg.sv
logic/pipe_regs.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/mem_arbiter.sv
logic/rv_core_top.sv
dv/rv_core_sva.sv
dv/rv_core_tb.sv

/* logic/decode_unit.sv */
`default_nettype none

`include "rv_core_macros.svh"

module decode_unit (
    input  logic                  clk,
    input  logic                  i_reset,
    input  rv_core_pkg::if_id_t   i_if_id,
    input  rv_core_pkg::reg_idx_t i_id_ex_rd,
    input  rv_core_pkg::reg_idx_t i_ex_mem_rd,
    input  rv_core_pkg::reg_idx_t i_mem_wb_rd,
    input  logic                  i_id_ex_we,
    input  logic                  i_ex_mem_we,
    input  logic                  i_mem_wb_we,
    input  logic                  i_wb_we,
    input  rv_core_pkg::reg_idx_t i_wb_rd,
    input  rv_core_pkg::word_t    i_wb_data,
    output rv_core_pkg::id_ex_t   o_id_ex,
    output logic                  o_stall
);
    import rv_core_pkg::*;

    word_t    regs [32];
    insn_t    insn;
    opcode_e  opcode;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm_i;
    word_t    imm_s;
    word_t    rs1_val;
    word_t    rs2_val;
    logic     use_rs1;
    logic     use_rs2;
    logic     legal;

    assign insn   = i_if_id.insn;
    assign opcode = opcode_e'(insn[6:0]);
    assign rs1    = insn[19:15];
    assign rs2    = insn[24:20];
    assign imm_i  = {{(`XLEN-12){insn[31]}}, insn[31:20]};
    assign imm_s  = {{(`XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};

    // x0 reads zero, and the writeback of this cycle wins over the array
    assign rs1_val = (rs1 == '0) ? '0 : (i_wb_we && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (i_wb_we && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb_we && i_wb_rd != '0)
        begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    always_comb
    begin
        o_id_ex          = '0;
        o_id_ex.rs1_data = rs1_val;
        o_id_ex.rs2_data = rs2_val;
        o_id_ex.rd       = insn[11:7];
        o_id_ex.alu_op   = ALU_ADD;
        use_rs1          = 1'b1;
        use_rs2          = 1'b0;
        legal            = i_if_id.valid;
        case (opcode)
            OPC_OP:
            begin
                use_rs2           = 1'b1;
                o_id_ex.reg_write = 1'b1;
                case ({insn[31:25], insn[14:12]})
                    {7'h00, 3'b000}: o_id_ex.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: o_id_ex.alu_op = ALU_SUB;
                    {7'h00, 3'b100}: o_id_ex.alu_op = ALU_XOR;
                    {7'h00, 3'b110}: o_id_ex.alu_op = ALU_OR;
                    {7'h00, 3'b111}: o_id_ex.alu_op = ALU_AND;
                    default:         legal = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                o_id_ex.imm       = imm_i;
                o_id_ex.alu_src   = 1'b1;
                o_id_ex.reg_write = 1'b1;
                legal             = legal && insn[14:12] == 3'b000;
            end
            OPC_LOAD:
            begin
                o_id_ex.imm        = imm_i;
                o_id_ex.alu_src    = 1'b1;
                o_id_ex.reg_write  = 1'b1;
                o_id_ex.mem_to_reg = 1'b1;
                legal              = legal && insn[14:12] == 3'b010;
            end
            OPC_STORE:
            begin
                use_rs2           = 1'b1;
                o_id_ex.imm       = imm_s;
                o_id_ex.alu_src   = 1'b1;
                o_id_ex.mem_write = 1'b1;
                legal             = legal && insn[14:12] == 3'b010;
            end
            OPC_JAL:
            begin
                // Only the self-jump is kept, as the halt
                use_rs1      = 1'b0;
                o_id_ex.halt = 1'b1;
                legal        = legal && insn == `HALT_INSN;
            end
            default: legal = 1'b0;
        endcase
        if (!legal)
        begin
            o_id_ex = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    function automatic logic raw_hit(input reg_idx_t src);
        return (src != '0) &&
               ((i_id_ex_we && i_id_ex_rd == src) ||
                (i_ex_mem_we && i_ex_mem_rd == src) ||
                (i_mem_wb_we && i_mem_wb_rd == src));
    endfunction

    // Interlock until the producer has left writeback
    always_comb
    begin
        o_stall = (use_rs1 && raw_hit(rs1)) || (use_rs2 && raw_hit(rs2));
    end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
`default_nettype none

module execute_unit (
    input  rv_core_pkg::id_ex_t  i_id_ex,
    output rv_core_pkg::ex_mem_t o_ex_mem
);
    import rv_core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t result;

    assign op_a = i_id_ex.rs1_data;
    // Immediate for ADDI and for load/store addresses
    assign op_b = i_id_ex.alu_src ? i_id_ex.imm : i_id_ex.rs2_data;

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: result = op_a + op_b;
        endcase
    end

    assign o_ex_mem = '{
        alu_result: result,
        store_data: i_id_ex.rs2_data,
        rd:         i_id_ex.rd,
        reg_write:  i_id_ex.reg_write,
        mem_write:  i_id_ex.mem_write,
        mem_to_reg: i_id_ex.mem_to_reg,
        halt:       i_id_ex.halt
    };

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`default_nettype none

`include "rv_core_macros.svh"

module fetch_unit (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_stall,
    input  logic               i_halt_seen,
    input  logic               i_grant,
    input  logic               i_rdata_valid,
    input  rv_core_pkg::insn_t i_rdata,
    output logic               o_req,
    output rv_core_pkg::addr_t o_addr,
    output rv_core_pkg::insn_t o_insn,
    output rv_core_pkg::addr_t o_pc,
    output logic               o_valid
);
    import rv_core_pkg::*;

    addr_t pc;
    addr_t fetch_pc;
    addr_t slot_pc;
    insn_t slot_insn;
    logic  slot_valid;
    logic  running;

    // No new request while the slot is full or decode is stalled
    assign o_req   = running && !i_halt_seen && !slot_valid && !i_stall;
    assign o_addr  = pc;
    assign o_valid = slot_valid || i_rdata_valid;
    assign o_insn  = slot_valid ? slot_insn : i_rdata;
    assign o_pc    = slot_valid ? slot_pc : fetch_pc;

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            pc         <= '0;
            slot_valid <= 1'b0;
            running    <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (i_grant && !i_stall)
            begin
                pc <= pc + addr_t'(4);
            end
            if (slot_valid)
            begin
                slot_valid <= i_stall;
            end
            else if (i_rdata_valid && i_stall)
            begin
                slot_valid <= 1'b1;
            end
        end
    end

    // Tag of the word in flight, and the parked instruction
    always_ff @(posedge clk)
    begin
        if (i_grant)
        begin
            fetch_pc <= pc;
        end
        if (!slot_valid && i_rdata_valid)
        begin
            slot_insn <= i_rdata;
            slot_pc   <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`default_nettype none

`include "rv_core_macros.svh"

module mem_arbiter (
    input  logic                clk,
    input  logic                i_load_we,
    input  rv_core_pkg::addr_t  i_load_addr,
    input  rv_core_pkg::word_t  i_load_data,
    input  logic                i_data_req,
    input  logic                i_data_we,
    input  rv_core_pkg::addr_t  i_data_addr,
    input  rv_core_pkg::word_t  i_data_wdata,
    input  logic                i_fetch_req,
    input  rv_core_pkg::addr_t  i_fetch_addr,
    output logic                o_fetch_grant,
    output rv_core_pkg::word_t  o_rdata,
    output rv_core_pkg::grant_e o_rdata_owner
);
    import rv_core_pkg::*;

    word_t  mem [`MEM_WORDS];
    grant_e grant;
    addr_t  addr;
    word_t  wdata;
    logic   we;
    logic [$clog2(`MEM_WORDS)-1:0] idx;

    // Loader first, then data, then fetch
    always_comb
    begin
        if (i_load_we)
            grant = GNT_LOAD_PORT;
        else if (i_data_req)
            grant = GNT_DATA;
        else if (i_fetch_req)
            grant = GNT_FETCH;
        else
            grant = GNT_NONE;
    end

    always_comb
    begin
        case (grant)
            GNT_LOAD_PORT:
            begin
                addr  = i_load_addr;
                we    = 1'b1;
                wdata = i_load_data;
            end
            GNT_DATA:
            begin
                addr  = i_data_addr;
                we    = i_data_we;
                wdata = i_data_wdata;
            end
            default:
            begin
                addr  = i_fetch_addr;
                we    = 1'b0;
                wdata = i_data_wdata;
            end
        endcase
    end

    assign o_fetch_grant = (grant == GNT_FETCH);
    assign idx           = addr[`PC_WIDTH-1:2];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[idx] <= wdata;
        end
        o_rdata       <= mem[idx];
        o_rdata_owner <= grant;
    end

endmodule

`default_nettype wire

/* logic/pipe_regs.sv */
`default_nettype none

`include "rv_core_macros.svh"

module if_id (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_stall,
    input  rv_core_pkg::if_id_t i_d,
    output rv_core_pkg::if_id_t o_q,
    output logic                o_end_of_program
);
    import rv_core_pkg::*;

    localparam if_id_t BUBBLE = '{pc: '0, insn: `NOP_INSN, valid: 1'b0};

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            o_q              <= BUBBLE;
            o_end_of_program <= 1'b0;
        end
        else if (!i_stall)
        begin
            // Anything fetched past the halt is dropped
            if (o_end_of_program || !i_d.valid)
            begin
                o_q <= BUBBLE;
            end
            else
            begin
                o_q <= i_d;
                if (i_d.insn == `HALT_INSN)
                begin
                    o_end_of_program <= 1'b1;
                end
            end
        end
    end

endmodule

module id_ex (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_stall,
    input  logic                i_bubble,
    input  rv_core_pkg::id_ex_t i_d,
    output rv_core_pkg::id_ex_t o_q
);

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            o_q <= '0;
        end
        else if (i_bubble)
        begin
            o_q <= '0;
        end
        else if (!i_stall)
        begin
            o_q <= i_d;
        end
    end

endmodule

module ex_mem (
    input  logic                 clk,
    input  logic                 i_reset,
    input  rv_core_pkg::ex_mem_t i_d,
    output rv_core_pkg::ex_mem_t o_q
);

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

module mem_wb (
    input  logic                 clk,
    input  logic                 i_reset,
    input  rv_core_pkg::mem_wb_t i_d,
    output rv_core_pkg::mem_wb_t o_q
);

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath and memory geometry
`define XLEN 32
`define MEM_WORDS 512
// Byte address spanning MEM_WORDS words of 4 bytes
`define PC_WIDTH 11

// ADDI x0,x0,0
`define NOP_INSN 32'h0000_0013
// JAL x0,0 marks the end of a program
`define HALT_INSN 32'h0000_006f

`define RESET_LEVEL 1'b1

`endif

/* logic/rv_core_pkg.sv */
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`PC_WIDTH-1:0] addr_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [31:0] insn_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // Memory user that owns the current cycle
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_LOAD_PORT,
        GNT_DATA,
        GNT_FETCH
    } grant_e;

    typedef struct packed {
        addr_t pc;
        insn_t insn;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_to_reg;
        logic     alu_src;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_to_reg;
        logic     halt;
    } ex_mem_t;

    // Load data comes straight from the memory into writeback
    typedef struct packed {
        word_t    alu_result;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_to_reg;
        logic     halt;
    } mem_wb_t;

endpackage

`default_nettype wire

/* logic/rv_core_top.sv */
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_top (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_load_we,
    input  rv_core_pkg::addr_t    i_load_addr,
    input  rv_core_pkg::word_t    i_load_data,
    output logic                  o_retire_valid,
    output rv_core_pkg::reg_idx_t o_retire_rd,
    output rv_core_pkg::word_t    o_retire_data,
    output logic                  o_halted
);
    import rv_core_pkg::*;

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    logic    fetch_req;
    logic    fetch_grant;
    logic    fetch_valid;
    addr_t   fetch_addr;
    addr_t   fetch_pc;
    insn_t   fetch_insn;
    logic    end_of_program;
    logic    stall;
    word_t   rdata;
    grant_e  rdata_owner;
    word_t   wb_data;

    fetch_unit u_fetch (
        .clk(clk), .i_reset(i_reset), .i_stall(stall), .i_halt_seen(end_of_program),
        .i_grant(fetch_grant), .i_rdata_valid(rdata_owner == GNT_FETCH), .i_rdata(rdata),
        .o_req(fetch_req), .o_addr(fetch_addr), .o_insn(fetch_insn), .o_pc(fetch_pc),
        .o_valid(fetch_valid)
    );

    assign if_id_d = '{pc: fetch_pc, insn: fetch_insn, valid: fetch_valid};

    if_id u_if_id (
        .clk(clk), .i_reset(i_reset), .i_stall(stall), .i_d(if_id_d), .o_q(if_id_q),
        .o_end_of_program(end_of_program)
    );

    decode_unit u_decode (
        .clk(clk), .i_reset(i_reset), .i_if_id(if_id_q),
        .i_id_ex_rd(id_ex_q.rd), .i_ex_mem_rd(ex_mem_q.rd), .i_mem_wb_rd(mem_wb_q.rd),
        .i_id_ex_we(id_ex_q.reg_write), .i_ex_mem_we(ex_mem_q.reg_write),
        .i_mem_wb_we(mem_wb_q.reg_write), .i_wb_we(mem_wb_q.reg_write),
        .i_wb_rd(mem_wb_q.rd), .i_wb_data(wb_data), .o_id_ex(id_ex_d), .o_stall(stall)
    );

    // Nothing stalls past decode, an interlock drops a bubble in instead
    id_ex u_id_ex (
        .clk(clk), .i_reset(i_reset), .i_stall(1'b0), .i_bubble(stall),
        .i_d(id_ex_d), .o_q(id_ex_q)
    );

    execute_unit u_execute (.i_id_ex(id_ex_q), .o_ex_mem(ex_mem_d));

    ex_mem u_ex_mem (.clk(clk), .i_reset(i_reset), .i_d(ex_mem_d), .o_q(ex_mem_q));

    mem_arbiter u_arbiter (
        .clk(clk), .i_load_we(i_load_we), .i_load_addr(i_load_addr),
        .i_load_data(i_load_data), .i_data_req(ex_mem_q.mem_write || ex_mem_q.mem_to_reg),
        .i_data_we(ex_mem_q.mem_write), .i_data_addr(ex_mem_q.alu_result[`PC_WIDTH-1:0]),
        .i_data_wdata(ex_mem_q.store_data), .i_fetch_req(fetch_req),
        .i_fetch_addr(fetch_addr), .o_fetch_grant(fetch_grant), .o_rdata(rdata),
        .o_rdata_owner(rdata_owner)
    );

    assign mem_wb_d = '{
        alu_result: ex_mem_q.alu_result,
        rd:         ex_mem_q.rd,
        reg_write:  ex_mem_q.reg_write,
        mem_to_reg: ex_mem_q.mem_to_reg,
        halt:       ex_mem_q.halt
    };

    mem_wb u_mem_wb (.clk(clk), .i_reset(i_reset), .i_d(mem_wb_d), .o_q(mem_wb_q));

    // Load data arrives from the memory in the writeback cycle
    assign wb_data = mem_wb_q.mem_to_reg ? rdata : mem_wb_q.alu_result;

    always_ff @(posedge clk)
    begin
        if (i_reset == `RESET_LEVEL)
        begin
            o_retire_valid <= 1'b0;
            o_halted       <= 1'b0;
        end
        else
        begin
            o_retire_valid <= mem_wb_q.reg_write && mem_wb_q.rd != '0;
            if (mem_wb_q.halt)
            begin
                o_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        o_retire_rd   <= mem_wb_q.rd;
        o_retire_data <= wb_data;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds and runs the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi

exit 0
